// File: Makefile
TOP = tb_customInstructionUnit

sim:
	verilator --binary --timing --assert -Wno-fatal -f files.f --top-module $(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; exit $$status
	! grep -q "Result: FAILED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// File: ciDecode.sv
`timescale 1ns/1ns
`default_nettype none

`include "ci_defs.svh"

module ciDecode import ciTypes_pkg::*; (
  input  wire             s_systemClock,
  input  wire             s_pllLocked,
  input  wire ciRequest_t ciRequest,
  output ciSelect_t       select,
  output ciOperands_t     operands
);

  localparam logic [`CI_ID_WIDTH-1:0] swapId    = `CI_SWAP_BYTE;
  localparam logic [`CI_ID_WIDTH-1:0] delayId   = `CI_DELAY;
  localparam logic [`CI_ID_WIDTH-1:0] profileId = `CI_PROFILE;

  ciSelect_t decoded;

  always_comb begin
    decoded = '0;
    if (ciRequest.start) begin
      case (ciRequest.id)
        swapId:    decoded.swap = 1'b1;
        delayId:   decoded.delay = 1'b1;
        profileId: decoded.profile = 1'b1;
        // Unmatched numbers still get an answer.
        default:   decoded.unknown = 1'b1;
      endcase
    end
  end

  // Strobes last exactly one cycle after the start edge.
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      select <= '0;
    end else begin
      select <= decoded;
    end
  end

  always_ff @(posedge s_systemClock) begin
    if (ciRequest.start) begin
      operands.operandA <= ciRequest.operandA;
      operands.operandB <= ciRequest.operandB;
    end
  end

endmodule

`default_nettype wire

// File: ciExecute.sv
`timescale 1ns/1ns
`default_nettype none

`include "ci_defs.svh"

module ciExecute import ciTypes_pkg::*; (
  input  wire              s_systemClock,
  input  wire              s_pllLocked,
  input  wire ciSelect_t   select,
  input  wire ciOperands_t operands,
  input  wire              stall,
  input  wire              busIdle,
  output ciResponse_t      swapResponse,
  output ciResponse_t      delayResponse,
  output ciResponse_t      profileResponse
);

  localparam int unsigned numBytes = `CI_DATA_WIDTH / 8;

  logic [`CI_DATA_WIDTH-1:0] swapped;

  // Byte i of the result takes the mirrored byte of operand A.
  always_comb begin
    for (int i = 0; i < numBytes; i++) begin
      swapped[8*i +: 8] = operands.operandA[8*(numBytes-1-i) +: 8];
    end
  end

  always_comb begin
    swapResponse.done   = select.swap;
    swapResponse.result = select.swap ? swapped : '0;
  end

  delayUnit delayUnit0 (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .start        (select.delay),
    .microseconds (operands.operandA),
    .response     (delayResponse)
  );

  profileCounters profileCounters0 (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .start        (select.profile),
    .operands     (operands),
    .stall        (stall),
    .busIdle      (busIdle),
    .response     (profileResponse)
  );

endmodule

`default_nettype wire

// File: ciResult.sv
`timescale 1ns/1ns
`default_nettype none

module ciResult import ciTypes_pkg::*; (
  input  wire              s_systemClock,
  input  wire              s_pllLocked,
  input  wire ciSelect_t   select,
  input  wire ciResponse_t swapResponse,
  input  wire ciResponse_t delayResponse,
  input  wire ciResponse_t profileResponse,
  output ciResponse_t      ciResponse
);

  ciResponse_t unknownResponse;
  ciResponse_t combined;
  logic        doneReg;
  logic [$bits(combined.result)-1:0] resultReg;

  // Unknown instructions finish at once with a zero result.
  always_comb begin
    unknownResponse.done   = select.unknown;
    unknownResponse.result = '0;
  end

  // Idle units drive zeros, so a plain OR merges them.
  assign combined = swapResponse | delayResponse | profileResponse | unknownResponse;

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      doneReg <= 1'b0;
    end else begin
      doneReg <= combined.done;
    end
  end

  always_ff @(posedge s_systemClock) begin
    resultReg <= combined.result;
  end

  assign ciResponse = '{done: doneReg, result: resultReg};

endmodule

`default_nettype wire

// File: ciTypes_pkg.sv
`default_nettype none

`include "ci_defs.svh"

package ciTypes_pkg;

  typedef struct packed {
    logic                      start;
    logic [`CI_ID_WIDTH-1:0]   id;
    logic [`CI_DATA_WIDTH-1:0] operandA;
    logic [`CI_DATA_WIDTH-1:0] operandB;
  } ciRequest_t;

  typedef struct packed {
    logic [`CI_DATA_WIDTH-1:0] operandA;
    logic [`CI_DATA_WIDTH-1:0] operandB;
  } ciOperands_t;

  // One strobe per function, at most one high at a time.
  typedef struct packed {
    logic swap;
    logic delay;
    logic profile;
    logic unknown;
  } ciSelect_t;

  typedef struct packed {
    logic                      done;
    logic [`CI_DATA_WIDTH-1:0] result;
  } ciResponse_t;

endpackage

`default_nettype wire

// File: ci_defs.svh
`ifndef CI_DEFS_SVH
`define CI_DEFS_SVH

// Operand and result width.
`define CI_DATA_WIDTH 32

// Width of the custom instruction number.
`define CI_ID_WIDTH 8

// Custom instruction numbers served by this unit.
`define CI_SWAP_BYTE 1
`define CI_DELAY 6
`define CI_PROFILE 11

// System clock runs at 25 MHz.
`define TICKS_PER_MICROSECOND 25

`endif

// File: ci_golden.txt
// Columns: instruction number, operand A, operand B, expected result (all hex).
// Profile lines carry 0 as expected, the testbench model supplies the value.
0000000b 00000000 00000000 00000000
00000001 12345678 00000000 78563412
00000001 a1b2c3d4 00000000 d4c3b2a1
00000002 deadbeef 00000000 00000000
000000ff 12345678 ffffffff 00000000
0000000b 00000000 00000001 00000000
00000006 00000002 00000000 00000000
0000000b 00000000 00000000 00000000
0000000b 00000001 00000000 00000000
0000000b 00000002 00000000 00000000
0000000b 00000003 00000000 00000000
0000000b 00000001 00000002 00000000
00000006 00000001 00000000 00000000
0000000b 00000001 00000000 00000000
0000000b 00000002 00000000 00000000
0000000b 00000000 00000004 00000000
0000000b 00000000 00000000 00000000
0000000b 00000003 00000000 00000000
00000006 00000000 00000000 00000000
00000001 ff00ff00 00000000 00ff00ff

// File: ci_properties.sv
`timescale 1ns/1ns
`default_nettype none

module ciProperties import ciTypes_pkg::*; (
  input wire              s_systemClock,
  input wire              s_pllLocked,
  input wire ciSelect_t   select,
  input wire ciResponse_t ciResponse
);

  // Done is a single-cycle strobe.
  doneOneCycle: assert property (
    @(posedge s_systemClock) disable iff (!s_pllLocked)
    ciResponse.done |=> !ciResponse.done
  ) else $error("done stayed high for more than one cycle");

  // An unknown instruction is answered at the next edge with a zero result.
  unknownZero: assert property (
    @(posedge s_systemClock) disable iff (!s_pllLocked)
    select.unknown |=> (ciResponse.done && ciResponse.result == '0)
  ) else $error("unknown instruction was not answered with zero");

endmodule

bind ciResult ciProperties ciProperties0 (
  .s_systemClock(s_systemClock),
  .s_pllLocked  (s_pllLocked),
  .select       (select),
  .ciResponse   (ciResponse)
);

`default_nettype wire

// File: customInstructionUnit.sv
`timescale 1ns/1ns
`default_nettype none

module customInstructionUnit import ciTypes_pkg::*; (
  input  wire             s_systemClock,
  input  wire             s_pllLocked,
  input  wire ciRequest_t ciRequest,
  input  wire             stall,
  input  wire             busIdle,
  output ciResponse_t     ciResponse
);

  ciSelect_t   select;
  ciOperands_t operands;
  ciResponse_t swapResponse;
  ciResponse_t delayResponse;
  ciResponse_t profileResponse;

  ciDecode ciDecode0 (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .ciRequest    (ciRequest),
    .select       (select),
    .operands     (operands)
  );

  ciExecute ciExecute0 (
    .s_systemClock  (s_systemClock),
    .s_pllLocked    (s_pllLocked),
    .select         (select),
    .operands       (operands),
    .stall          (stall),
    .busIdle        (busIdle),
    .swapResponse   (swapResponse),
    .delayResponse  (delayResponse),
    .profileResponse(profileResponse)
  );

  ciResult ciResult0 (
    .s_systemClock  (s_systemClock),
    .s_pllLocked    (s_pllLocked),
    .select         (select),
    .swapResponse   (swapResponse),
    .delayResponse  (delayResponse),
    .profileResponse(profileResponse),
    .ciResponse     (ciResponse)
  );

endmodule

`default_nettype wire

// File: delayUnit.sv
`timescale 1ns/1ns
`default_nettype none

`include "ci_defs.svh"

module delayUnit import ciTypes_pkg::*; (
  input  wire                      s_systemClock,
  input  wire                      s_pllLocked,
  input  wire                      start,
  input  wire [`CI_DATA_WIDTH-1:0] microseconds,
  output ciResponse_t              response
);

  // Wide enough to hold the largest operand times the tick count.
  localparam int unsigned countWidth =
    `CI_DATA_WIDTH + $clog2(`TICKS_PER_MICROSECOND);

  logic [countWidth-1:0] count;
  logic [countWidth-1:0] loadValue;
  logic                  busy;

  assign loadValue = countWidth'(microseconds) * countWidth'(`TICKS_PER_MICROSECOND);

  // A zero delay answers right away, like a single-cycle function.
  always_comb begin
    response.done   = (start && microseconds == '0) || (busy && count == '0);
    response.result = '0;
  end

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      busy  <= 1'b0;
      count <= '0;
    end else if (start) begin
      busy  <= (microseconds != '0);
      count <= loadValue;
    end else if (busy) begin
      if (count == '0) begin
        busy <= 1'b0;
      end else begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: files.f
+incdir+.
ciTypes_pkg.sv
ciDecode.sv
delayUnit.sv
profileCounters.sv
ciExecute.sv
ciResult.sv
customInstructionUnit.sv
ci_properties.sv
tb_customInstructionUnit.sv

// File: profileCounters.sv
`timescale 1ns/1ns
`default_nettype none

`include "ci_defs.svh"

module profileCounters import ciTypes_pkg::*; (
  input  wire              s_systemClock,
  input  wire              s_pllLocked,
  input  wire              start,
  input  wire ciOperands_t operands,
  input  wire              stall,
  input  wire              busIdle,
  output ciResponse_t      response
);

  localparam int unsigned numCounters = 3;

  logic [numCounters-1:0][`CI_DATA_WIDTH-1:0] counters;
  logic [numCounters-1:0]                     events;
  logic [1:0]                                 index;
  logic                                       enabled;
  logic                                       clear;

  // Counter 0 counts cycles, 1 stall cycles, 2 bus-idle cycles.
  assign events = {busIdle, stall, 1'b1};
  assign index  = operands.operandA[1:0];
  assign clear  = start && operands.operandB[2];

  // Disable is applied after enable, so it wins when both are set.
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      enabled <= 1'b0;
    end else if (start) begin
      if (operands.operandB[0]) begin
        enabled <= 1'b1;
      end
      if (operands.operandB[1]) begin
        enabled <= 1'b0;
      end
    end
  end

  // The old enable still counts at the control edge, unless cleared.
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      counters <= '0;
    end else begin
      for (int i = 0; i < numCounters; i++) begin
        if (clear) begin
          counters[i] <= '0;
        end else if (enabled && events[i]) begin
          counters[i] <= counters[i] + 1'b1;
        end
      end
    end
  end

  // Reads return the value from before the control edge.
  always_comb begin
    response.done   = start;
    response.result = '0;
    if (start && index != 2'd3) begin
      response.result = counters[index];
    end
  end

endmodule

`default_nettype wire

// File: tb_customInstructionUnit.sv
`timescale 1ns/1ns
`default_nettype none

`include "ci_defs.svh"

module tb_customInstructionUnit import ciTypes_pkg::*; ();

  localparam int numTests = 20;

  logic        s_systemClock;
  logic        s_pllLocked;
  ciRequest_t  ciRequest;
  logic        stall;
  logic        busIdle;
  ciResponse_t ciResponse;

  logic [31:0] golden [0:numTests*4-1];
  logic [31:0] lfsrState;
  // Entry 3 is never counted, so index 3 reads zero.
  logic [31:0] modelCount [0:3];
  logic [31:0] modelRead;
  logic        modelEnabled;
  logic        controlPending;
  logic [31:0] pendingA;
  logic [31:0] pendingB;
  logic [3:0]  sampledEvents;
  int          errorCount;
  int          failedTests;

  customInstructionUnit dut0 (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .ciRequest    (ciRequest),
    .stall        (stall),
    .busIdle      (busIdle),
    .ciResponse   (ciResponse)
  );

  always #20 s_systemClock = ~s_systemClock;

  function automatic logic [31:0] nextLfsr(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  function automatic string kindName(input logic [`CI_ID_WIDTH-1:0] id);
    case (id)
      `CI_SWAP_BYTE: return "swap";
      `CI_DELAY:     return "delay";
      `CI_PROFILE:   return "profile";
      default:       return "unknown";
    endcase
  endfunction

  // Stall and bus-idle take one fresh LFSR bit each per cycle.
  always @(posedge s_systemClock) begin
    lfsrState = nextLfsr(lfsrState);
    stall <= lfsrState[0];
    lfsrState = nextLfsr(lfsrState);
    busIdle <= lfsrState[0];
  end

  // Profile counter model, stepped on every rising edge with the inputs the DUT samples.
  always @(posedge s_systemClock) begin
    if (!s_pllLocked) begin
      for (int i = 0; i < 4; i++) begin
        modelCount[i] = '0;
      end
      modelEnabled   = 1'b0;
      controlPending = 1'b0;
      modelRead      = '0;
    end else begin
      sampledEvents = {1'b0, busIdle, stall, 1'b1};
      if (controlPending) begin
        modelRead = modelCount[pendingA[1:0]];
      end
      for (int i = 0; i < 4; i++) begin
        if (controlPending && pendingB[2]) begin
          modelCount[i] = '0;
        end else if (modelEnabled && sampledEvents[i]) begin
          modelCount[i] = modelCount[i] + 1;
        end
      end
      if (controlPending && pendingB[0]) begin
        modelEnabled = 1'b1;
      end
      if (controlPending && pendingB[1]) begin
        modelEnabled = 1'b0;
      end
      controlPending = ciRequest.start && (ciRequest.id == `CI_PROFILE);
      pendingA       = ciRequest.operandA;
      pendingB       = ciRequest.operandB;
    end
  end

  // Start is high for exactly one cycle and the task returns at the sampling edge.
  task automatic issueRequest(input logic [`CI_ID_WIDTH-1:0] id, input logic [31:0] a,
                              input logic [31:0] b);
    @(posedge s_systemClock);
    ciRequest <= '{start: 1'b1, id: id, operandA: a, operandB: b};
    @(posedge s_systemClock);
    ciRequest.start <= 1'b0;
  endtask

  task automatic waitForDone(input int limit, output int latency, output bit timedOut);
    bit seen;
    seen    = 1'b0;
    latency = 0;
    while (!seen && latency < limit) begin
      @(posedge s_systemClock);
      latency++;
      @(negedge s_systemClock);
      seen = ciResponse.done;
    end
    timedOut = !seen;
  endtask

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] got, inout int errors);
    assert (got === expected) else begin
      $display("mismatch at %0t: %s expected %h got %h", $time, name, expected, got);
      errors++;
    end
  endtask

  initial begin : stimulus
    logic [`CI_ID_WIDTH-1:0] id;
    logic [31:0]             operandA;
    logic [31:0]             operandB;
    logic [31:0]             expected;
    logic                    isDelay;
    int                      latency;
    int                      minLatency;
    int                      limit;
    int                      testErrors;
    int                      t;
    bit                      timedOut;
    s_systemClock = 1'b0;
    s_pllLocked   = 1'b0;
    ciRequest     = '0;
    stall         = 1'b0;
    busIdle       = 1'b0;
    lfsrState     = 32'h5cb8;
    errorCount    = 0;
    failedTests   = 0;
    timedOut      = 1'b0;
    $readmemh("ci_golden.txt", golden);
    repeat (4) @(posedge s_systemClock);
    s_pllLocked <= 1'b1;
    repeat (2) begin
      @(negedge s_systemClock);
      assert (ciResponse.done === 1'b0) else begin
        $display("done was high at %0t while no request was pending", $time);
        errorCount++;
      end
    end
    t = 0;
    while (t < numTests && !timedOut) begin
      id         = golden[4*t][`CI_ID_WIDTH-1:0];
      operandA   = golden[4*t+1];
      operandB   = golden[4*t+2];
      expected   = golden[4*t+3];
      isDelay    = (id == `CI_DELAY) && (operandA != '0);
      minLatency = isDelay ? int'(operandA) * `TICKS_PER_MICROSECOND : 1;
      limit      = minLatency + 16;
      testErrors = 0;
      issueRequest(id, operandA, operandB);
      waitForDone(limit, latency, timedOut);
      if (timedOut) begin
        $display("test %0d got no done from the DUT within %0d cycles", t, limit);
        testErrors++;
      end else begin
        if (id == `CI_PROFILE) begin
          expected = modelRead;
        end
        checkValue("ciResponse.result", expected, ciResponse.result, testErrors);
        if (isDelay) begin
          assert (latency >= minLatency) else begin
            $display("at %0t the delay ended after %0d cycles, at least %0d were due",
                     $time, latency, minLatency);
            testErrors++;
          end
        end else begin
          assert (latency == 1) else begin
            $display("at %0t the answer came after %0d cycles instead of 1", $time, latency);
            testErrors++;
          end
        end
      end
      if (testErrors > 0) begin
        failedTests++;
      end
      errorCount += testErrors;
      $display("test %0d %s a=%h b=%h result=%h latency=%0d %s", t, kindName(id), operandA,
               operandB, ciResponse.result, latency, (testErrors == 0) ? "ok" : "bad");
      t++;
    end
    $display("%0d tests run, %0d failed, %0d errors", t, failedTests, errorCount);
    if (errorCount == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
